// File: hw/vdp_params.svh
////////////////////////////////////////
// vdp parameters
// frame timing, memory size, register map
////////////////////////////////////////
`ifndef VDP_PARAMS_SVH
`define VDP_PARAMS_SVH

// horizontal, in pixels
`define VDP_H_VISIBLE       16
`define VDP_H_TOTAL         24
`define VDP_H_SYNC_START    18
`define VDP_H_SYNC_END      21
// vertical, in lines
`define VDP_V_VISIBLE       8
`define VDP_V_TOTAL         14
`define VDP_V_SYNC_START    10
`define VDP_V_SYNC_END      11

`define VDP_VRAM_AW         12          // 4K words

// cpu register numbers
`define VDP_REG_VRAM_ADDR   4'd0
`define VDP_REG_VRAM_DATA   4'd1
`define VDP_REG_PAL_ADDR    4'd2
`define VDP_REG_PAL_DATA    4'd3
`define VDP_REG_DISP_BASE   4'd4
`define VDP_REG_WR_MASK     4'd5
`define VDP_REG_INTR_CTRL   4'd6
`define VDP_REG_INTR_STATUS 4'd7

`endif

// File: hw/vdp_pkg.sv
////////////////////////////////////////
// vdp types
// shared widths and bundled signals
////////////////////////////////////////
package vdp_pkg;

`include "vdp_params.svh"

typedef logic [`VDP_VRAM_AW-1:0] vram_addr_t;  // word address
typedef logic [15:0]             vram_word_t;
typedef logic [3:0]              nib_mask_t;   // one bit per nibble
typedef logic [3:0]              color_idx_t;
typedef logic [11:0]             rgb_t;        // red in 11:8
typedef logic [3:0]              intr_bits_t;  // bit 0 vblank, 3:1 cpu
typedef logic [3:0]              reg_num_t;
typedef logic [7:0]              scan_pos_t;

// one request on the single vram port
typedef struct packed {
    logic       sel;
    logic       wr;
    nib_mask_t  mask;
    vram_addr_t addr;
    vram_word_t data;
} vram_req_t;

typedef struct packed {
    logic       en;
    color_idx_t addr;
    rgb_t       data;
} pal_wr_t;

typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;       // visible pixel
} video_sync_t;

endpackage

// File: hw/vdp_bus_regs.sv
////////////////////////////////////////
// vdp cpu registers
// byte bus to word registers, vram and
// palette access, interrupt commands
////////////////////////////////////////
`timescale 1ns/100ps
`include "vdp_params.svh"

module vdp_bus_regs(
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire logic                bus_cs_n_i,     // access strobe, active low
    input  wire logic                bus_rd_nwr_i,   // 1 = read
    input  wire vdp_pkg::reg_num_t   bus_reg_num_i,
    input  wire logic                bus_bytesel_i,  // 1 = odd byte
    input  wire logic [7:0]          bus_data_i,
    output logic [7:0]               bus_data_o,
    output vdp_pkg::vram_req_t       vram_req_o,     // held until granted
    input  wire logic                bus_grant_i,
    input  wire vdp_pkg::vram_word_t vram_data_i,    // prefetched word
    output vdp_pkg::pal_wr_t         pal_wr_o,
    output vdp_pkg::vram_addr_t      disp_base_o,
    output vdp_pkg::intr_bits_t      intr_mask_o,
    output vdp_pkg::intr_bits_t      intr_clear_o,   // one cycle pulses
    output vdp_pkg::intr_bits_t      intr_set_o,
    input  wire vdp_pkg::intr_bits_t intr_status_i
);

logic [7:0]          hi_byte_q;      // even byte waits here
logic                commit;         // odd byte write completes a word
vdp_pkg::vram_word_t wr_word;
vdp_pkg::vram_word_t rd_word;        // value of the addressed register
vdp_pkg::vram_addr_t vram_addr_q;
vdp_pkg::color_idx_t pal_idx_q;
vdp_pkg::nib_mask_t  wr_mask_q;

assign commit  = !bus_cs_n_i && !bus_rd_nwr_i && bus_bytesel_i;
assign wr_word = {hi_byte_q, bus_data_i};

// readback mux
always_comb begin
    case (bus_reg_num_i)
        `VDP_REG_VRAM_ADDR:   rd_word = 16'(vram_addr_q);
        `VDP_REG_VRAM_DATA:   rd_word = vram_data_i;
        `VDP_REG_PAL_ADDR:    rd_word = 16'(pal_idx_q);
        `VDP_REG_PAL_DATA:    rd_word = 16'(pal_wr_o.data);  // last colour written
        `VDP_REG_DISP_BASE:   rd_word = 16'(disp_base_o);
        `VDP_REG_WR_MASK:     rd_word = 16'(wr_mask_q);
        `VDP_REG_INTR_CTRL:   rd_word = 16'(intr_mask_o);
        `VDP_REG_INTR_STATUS: rd_word = 16'(intr_status_i);
        default:              rd_word = '0;
    endcase
end

// byte lanes
always_ff @(posedge clk) begin
    if (!bus_cs_n_i) begin
        if (bus_rd_nwr_i) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];  // held till next strobe
        end else if (!bus_bytesel_i) begin
            hi_byte_q <= bus_data_i;
        end
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        vram_req_o   <= '0;
        pal_wr_o     <= '0;
        vram_addr_q  <= '0;
        pal_idx_q    <= '0;
        wr_mask_q    <= '0;
        disp_base_o  <= '0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
        intr_set_o   <= '0;
    end else begin
        pal_wr_o.en  <= 1'b0;
        intr_clear_o <= '0;
        intr_set_o   <= '0;
        if (vram_req_o.sel && bus_grant_i) begin
            if (vram_req_o.wr) begin
                // write done, step on and prefetch next word
                vram_addr_q     <= vram_addr_q + 1'b1;
                vram_req_o.wr   <= 1'b0;
                vram_req_o.addr <= vram_addr_q + 1'b1;
            end else begin
                vram_req_o.sel <= 1'b0;     // read issued, main captures it
            end
        end
        if (commit) begin
            case (bus_reg_num_i)
                `VDP_REG_VRAM_ADDR: begin
                    vram_addr_q <= vdp_pkg::vram_addr_t'(wr_word);
                    vram_req_o  <= '{sel: 1'b1, wr: 1'b0, mask: '0,
                                     addr: vdp_pkg::vram_addr_t'(wr_word), data: '0};
                end
                `VDP_REG_VRAM_DATA: begin
                    vram_req_o <= '{sel: 1'b1, wr: 1'b1, mask: wr_mask_q,
                                    addr: vram_addr_q, data: wr_word};
                end
                `VDP_REG_PAL_ADDR:  pal_idx_q <= vdp_pkg::color_idx_t'(wr_word);
                `VDP_REG_PAL_DATA: begin
                    pal_wr_o  <= '{en: 1'b1, addr: pal_idx_q, data: vdp_pkg::rgb_t'(wr_word)};
                    pal_idx_q <= pal_idx_q + 1'b1;
                end
                `VDP_REG_DISP_BASE: disp_base_o <= vdp_pkg::vram_addr_t'(wr_word);
                `VDP_REG_WR_MASK:   wr_mask_q <= vdp_pkg::nib_mask_t'(wr_word);
                `VDP_REG_INTR_CTRL: begin
                    intr_mask_o  <= wr_word[3:0];
                    intr_clear_o <= wr_word[11:8];
                end
                `VDP_REG_INTR_STATUS: intr_set_o <= wr_word[3:0];   // cpu raised
                default: ;
            endcase
        end
    end
end

endmodule

// File: hw/vdp_video_timing.sv
////////////////////////////////////////
// vdp video timing
// scan counters, syncs, display enable
////////////////////////////////////////
`timescale 1ns/100ps
`include "vdp_params.svh"

module vdp_video_timing(
    input  wire logic            clk,
    input  wire logic            reset_i,
    output vdp_pkg::scan_pos_t   h_o,
    output vdp_pkg::scan_pos_t   v_o,
    output vdp_pkg::video_sync_t sync_o,
    output logic                 vblank_start_o
);

logic h_last;
logic v_last;

assign h_last = (h_o == 8'(`VDP_H_TOTAL - 1));
assign v_last = (v_o == 8'(`VDP_V_TOTAL - 1));

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_o <= '0;
        v_o <= '0;
    end else begin
        if (h_last) begin
            h_o <= '0;
            v_o <= v_last ? '0 : v_o + 1'b1;    // next line or wrap frame
        end else begin
            h_o <= h_o + 1'b1;
        end
    end
end

// decoded straight from the counters, active high
assign sync_o.hsync = (h_o >= 8'(`VDP_H_SYNC_START)) && (h_o < 8'(`VDP_H_SYNC_END));
assign sync_o.vsync = (v_o >= 8'(`VDP_V_SYNC_START)) && (v_o < 8'(`VDP_V_SYNC_END));
assign sync_o.de    = (h_o < 8'(`VDP_H_VISIBLE)) && (v_o < 8'(`VDP_V_VISIBLE));

// first pixel of the first blank line
assign vblank_start_o = (h_o == '0) && (v_o == 8'(`VDP_V_VISIBLE));

endmodule

// File: hw/vdp_pixel_fetch.sv
////////////////////////////////////////
// vdp pixel fetch
// vram word reads to colour indices
////////////////////////////////////////
`timescale 1ns/100ps
`include "vdp_params.svh"

module vdp_pixel_fetch(
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire vdp_pkg::scan_pos_t   h_i,
    input  wire vdp_pkg::scan_pos_t   v_i,
    input  wire vdp_pkg::video_sync_t sync_i,
    input  wire vdp_pkg::vram_addr_t  disp_base_i,
    output vdp_pkg::vram_req_t        vram_req_o,    // read only
    input  wire vdp_pkg::vram_word_t  vram_data_i,   // word captured in main
    output vdp_pkg::color_idx_t       color_idx_o,   // 3 cycles after h_i
    output vdp_pkg::video_sync_t      sync_o
);

vdp_pkg::vram_addr_t        word_addr_q;     // next word to fetch
vdp_pkg::vram_word_t        shift_q;         // leftmost pixel in top nibble
vdp_pkg::video_sync_t [2:0] sync_dly_q;
logic                       line_req;
logic                       next_req;
logic                       fetch;

// words 1..3 at h = 2, 6, 10 of a visible line
assign line_req = (h_i[1:0] == 2'd2) && (h_i < 8'(`VDP_H_VISIBLE - 2))
                  && (v_i < 8'(`VDP_V_VISIBLE));
// word 0 of the next visible line, two slots before the wrap
assign next_req = (h_i == 8'(`VDP_H_TOTAL - 2))
                  && ((v_i < 8'(`VDP_V_VISIBLE - 1)) || (v_i == 8'(`VDP_V_TOTAL - 1)));
assign fetch    = line_req || next_req;

assign vram_req_o = '{sel: fetch, wr: 1'b0, mask: '0, addr: word_addr_q, data: '0};

always_ff @(posedge clk) begin
    if (reset_i) begin
        word_addr_q <= '0;
        sync_dly_q  <= '0;
    end else begin
        if (fetch) begin
            word_addr_q <= word_addr_q + 1'b1;     // video always wins the port
        end else if ((v_i == 8'(`VDP_V_TOTAL - 1)) && (h_i == '0)) begin
            word_addr_q <= disp_base_i;           // frame start
        end
        sync_dly_q <= {sync_dly_q[1:0], sync_i};
    end
end

// word lands in main at h = 4k, loaded here at 4k+1
always_ff @(posedge clk) begin
    if (h_i[1:0] == 2'd1) begin
        shift_q <= vram_data_i;
    end else begin
        shift_q <= {shift_q[11:0], 4'h0};
    end
    color_idx_o <= shift_q[15:12];
end

assign sync_o = sync_dly_q[2];

endmodule

// File: hw/vdp_vram.sv
////////////////////////////////////////
// vdp video ram
// 4K x 16 single port, nibble writes
////////////////////////////////////////
`timescale 1ns/100ps
`include "vdp_params.svh"

module vdp_vram(
    input  wire logic               clk,
    input  wire vdp_pkg::vram_req_t req_i,
    output vdp_pkg::vram_word_t     data_o    // valid the cycle after sel
);

vdp_pkg::vram_word_t mem [0:(1 << `VDP_VRAM_AW)-1];

always_ff @(posedge clk) begin
    if (req_i.sel) begin
        if (req_i.wr) begin
            for (int n = 0; n < 4; n++) begin
                if (req_i.mask[n]) begin
                    mem[req_i.addr][n*4 +: 4] <= req_i.data[n*4 +: 4];
                end
            end
        end
        data_o <= mem[req_i.addr];   // old data on a write
    end
end

endmodule

// File: hw/vdp_palette.sv
////////////////////////////////////////
// vdp palette
// 16 x 12 bit colour ram
////////////////////////////////////////
`timescale 1ns/100ps

module vdp_palette(
    input  wire logic                clk,
    input  wire vdp_pkg::pal_wr_t    wr_i,
    input  wire vdp_pkg::color_idx_t rd_idx_i,
    output vdp_pkg::rgb_t            rd_data_o
);

vdp_pkg::rgb_t mem [0:15];

always_ff @(posedge clk) begin
    if (wr_i.en) begin
        mem[wr_i.addr] <= wr_i.data;
    end
    rd_data_o <= mem[rd_idx_i];     // one cycle lookup
end

endmodule

// File: hw/vdp_main.sv
////////////////////////////////////////
// vdp main
// vram arbiter, interrupts, rgb output
////////////////////////////////////////
`timescale 1ns/100ps

module vdp_main(
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire logic              bus_cs_n_i,
    input  wire logic              bus_rd_nwr_i,
    input  wire vdp_pkg::reg_num_t bus_reg_num_i,
    input  wire logic              bus_bytesel_i,
    input  wire logic [7:0]        bus_data_i,
    output logic [7:0]             bus_data_o,
    output logic                   bus_intr_o,         // one cycle strobe
    output logic [3:0]             red_o,
    output logic [3:0]             green_o,
    output logic [3:0]             blue_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   dv_de_o
);

vdp_pkg::vram_req_t   bus_req;
vdp_pkg::vram_req_t   vid_req;
vdp_pkg::vram_req_t   ram_req;
logic                 bus_grant;
logic                 vid_grant;
logic                 bus_load_q;     // bus read issued last cycle
logic                 vid_load_q;
vdp_pkg::vram_word_t  ram_data;
vdp_pkg::vram_word_t  bus_word_q;
vdp_pkg::vram_word_t  vid_word_q;
vdp_pkg::pal_wr_t     pal_wr;
vdp_pkg::vram_addr_t  disp_base;
vdp_pkg::scan_pos_t   h;
vdp_pkg::scan_pos_t   v;
vdp_pkg::video_sync_t tim_sync;
vdp_pkg::video_sync_t fetch_sync;
vdp_pkg::video_sync_t sync_q;         // lines up with palette read
logic                 vblank_start;
vdp_pkg::color_idx_t  color_idx;
vdp_pkg::rgb_t        pal_rgb;
vdp_pkg::intr_bits_t  intr_mask;
vdp_pkg::intr_bits_t  intr_clear;
vdp_pkg::intr_bits_t  intr_set;
vdp_pkg::intr_bits_t  intr_signal;
vdp_pkg::intr_bits_t  intr_status;

// fixed priority, video first
assign vid_grant = vid_req.sel;
assign bus_grant = bus_req.sel && !vid_req.sel;
assign ram_req   = vid_grant ? vid_req : bus_req;

always_ff @(posedge clk) begin
    if (reset_i) begin
        vid_load_q <= 1'b0;
        bus_load_q <= 1'b0;
    end else begin
        vid_load_q <= vid_grant;
        bus_load_q <= bus_grant && !bus_req.wr;
    end
end

// keep each side's last read word
always_ff @(posedge clk) begin
    if (vid_load_q) begin
        vid_word_q <= ram_data;
    end
    if (bus_load_q) begin
        bus_word_q <= ram_data;
    end
end

vdp_bus_regs i_bus_regs(
    .clk(clk), .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
    .vram_req_o(bus_req), .bus_grant_i(bus_grant), .vram_data_i(bus_word_q),
    .pal_wr_o(pal_wr), .disp_base_o(disp_base),
    .intr_mask_o(intr_mask), .intr_clear_o(intr_clear), .intr_set_o(intr_set),
    .intr_status_i(intr_status)
);

vdp_video_timing i_timing(
    .clk(clk), .reset_i(reset_i),
    .h_o(h), .v_o(v), .sync_o(tim_sync), .vblank_start_o(vblank_start)
);

vdp_pixel_fetch i_fetch(
    .clk(clk), .reset_i(reset_i),
    .h_i(h), .v_i(v), .sync_i(tim_sync), .disp_base_i(disp_base),
    .vram_req_o(vid_req), .vram_data_i(vid_word_q),
    .color_idx_o(color_idx), .sync_o(fetch_sync)
);

vdp_vram i_vram(.clk(clk), .req_i(ram_req), .data_o(ram_data));

vdp_palette i_palette(.clk(clk), .wr_i(pal_wr), .rd_idx_i(color_idx), .rd_data_o(pal_rgb));

// output stage, blank outside de
always_ff @(posedge clk) begin
    if (reset_i) begin
        sync_q  <= '0;
        hsync_o <= 1'b0;
        vsync_o <= 1'b0;
        dv_de_o <= 1'b0;
        {red_o, green_o, blue_o} <= '0;
    end else begin
        sync_q  <= fetch_sync;
        hsync_o <= sync_q.hsync;
        vsync_o <= sync_q.vsync;
        dv_de_o <= sync_q.de;
        {red_o, green_o, blue_o} <= sync_q.de ? pal_rgb : '0;
    end
end

assign intr_signal = intr_set | {3'b000, vblank_start};

// strobe only for new, unmasked sources
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o  <= 1'b0;
        intr_status <= '0;
    end else begin
        bus_intr_o  <= |(intr_signal & intr_mask & ~intr_status);
        intr_status <= (intr_status | intr_signal) & ~intr_clear;   // clear wins
    end
end

endmodule

// File: tb/vdp_properties.sv
////////////////////////////////////////
// vdp properties
// arbiter, interrupt strobe, blanking
////////////////////////////////////////
`timescale 1ns/100ps

module vdp_properties(
    input wire logic                clk,
    input wire logic                reset_i,
    input wire logic                vid_grant_i,
    input wire logic                bus_grant_i,
    input wire logic                de_i,
    input wire vdp_pkg::rgb_t       rgb_i,
    input wire logic                intr_i,       // bus_intr_o strobe
    input wire vdp_pkg::intr_bits_t status_i,
    input wire vdp_pkg::intr_bits_t clear_i,
    input wire vdp_pkg::intr_bits_t signal_i
);

// single ram port
one_grant: assert property (@(posedge clk) disable iff (reset_i)
    !(vid_grant_i && bus_grant_i))
    else $error("vram port granted to video and bus in the same cycle");

blank_rgb: assert property (@(posedge clk) disable iff (reset_i)
    !de_i |-> (rgb_i == '0))
    else $error("rgb outputs not zero outside display enable");

strobe_once: assert property (@(posedge clk) disable iff (reset_i)
    intr_i |=> !intr_i)
    else $error("interrupt strobe high for two cycles");

// clear wins over a new signal in the same cycle
clear_holds: assert property (@(posedge clk) disable iff (reset_i)
    (|clear_i) |=> ((status_i & $past(clear_i) & ~$past(signal_i)) == '0))
    else $error("cleared interrupt status bit still set");

endmodule

bind vdp_main vdp_properties i_props(
    .clk(clk),
    .reset_i(reset_i),
    .vid_grant_i(vid_grant),
    .bus_grant_i(bus_grant),
    .de_i(dv_de_o),
    .rgb_i({red_o, green_o, blue_o}),
    .intr_i(bus_intr_o),
    .status_i(intr_status),
    .clear_i(intr_clear),
    .signal_i(intr_signal)
);

// File: tb/vdp_tb.sv
////////////////////////////////////////
// vdp testbench
// bus access, vram and palette model,
// frame checker, interrupt sequence
////////////////////////////////////////
`timescale 1ns/100ps
`include "vdp_params.svh"

module vdp_tb;

localparam int FRAME_CYCLES = `VDP_H_TOTAL * `VDP_V_TOTAL;
localparam int FRAME_PIXELS = `VDP_H_VISIBLE * `VDP_V_VISIBLE;   // 128
localparam int NWORDS       = FRAME_PIXELS / 4;                   // words per frame
localparam int SYNC_TIMEOUT = 2 * FRAME_CYCLES;
localparam vdp_pkg::vram_addr_t AREA = 12'h040;   // two frames of test data from here

logic                clk;
logic                reset_i;
logic                bus_cs_n_i;
logic                bus_rd_nwr_i;
vdp_pkg::reg_num_t   bus_reg_num_i;
logic                bus_bytesel_i;
logic [7:0]          bus_data_i;
logic [7:0]          bus_data_o;
logic                bus_intr_o;
logic [3:0]          red_o;
logic [3:0]          green_o;
logic [3:0]          blue_o;
logic                hsync_o;
logic                vsync_o;
logic                dv_de_o;

integer              seed;
int                  intr_pulses;                 // strobes seen so far
vdp_pkg::vram_word_t vram_model [0:(1 << `VDP_VRAM_AW)-1];
vdp_pkg::rgb_t       pal_model [0:15];
vdp_pkg::nib_mask_t  mask_model;
vdp_pkg::intr_bits_t status_model;

vdp_main i_dut(.*);

always #5 clk = ~clk;

always @(negedge clk) begin
    if (bus_intr_o) begin
        intr_pulses <= intr_pulses + 1;
    end
end

task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
endtask

task automatic check_word(input string name, input vdp_pkg::vram_word_t got,
                          input vdp_pkg::vram_word_t exp);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %s got %h exp %h", name, got, exp));
    end
endtask

task automatic check_rgb(input string name, input vdp_pkg::rgb_t got, input vdp_pkg::rgb_t exp);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %s got %h exp %h", name, got, exp));
    end
endtask

task automatic check_sync(input string name, input vdp_pkg::video_sync_t got,
                          input vdp_pkg::video_sync_t exp);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %s got %h exp %h", name, got, exp));
    end
endtask

task automatic check_intr(input string name, input vdp_pkg::intr_bits_t got,
                          input vdp_pkg::intr_bits_t exp);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %s got %h exp %h", name, got, exp));
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        abort_run($sformatf("[FAIL] %s got %h exp %h", name, got, exp));
    end
endtask

// one strobe cycle, then idle so accesses stay 4+ cycles apart
task automatic bus_access(input logic rd, input vdp_pkg::reg_num_t num, input logic odd,
                          input logic [7:0] wdata, output logic [7:0] rdata);
    @(posedge clk);
    #1;
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = rd;
    bus_reg_num_i = num;
    bus_bytesel_i = odd;
    bus_data_i    = wdata;
    @(posedge clk);
    #1;
    bus_cs_n_i = 1'b1;
    rdata      = bus_data_o;      // registered on the strobe edge
    repeat (3) @(posedge clk);
endtask

task automatic write_reg(input vdp_pkg::reg_num_t num, input vdp_pkg::vram_word_t data);
    logic [7:0] ignored;
    bus_access(1'b0, num, 1'b0, data[15:8], ignored);   // high byte first
    bus_access(1'b0, num, 1'b1, data[7:0], ignored);    // commit
endtask

task automatic read_reg(input vdp_pkg::reg_num_t num, output vdp_pkg::vram_word_t data);
    bus_access(1'b1, num, 1'b0, 8'h00, data[15:8]);
    bus_access(1'b1, num, 1'b1, 8'h00, data[7:0]);
endtask

// reference write, only nibbles enabled by the mask
task automatic model_write(input vdp_pkg::vram_addr_t addr, input vdp_pkg::vram_word_t data);
    for (int n = 0; n < 4; n++) begin
        if (mask_model[n]) begin
            vram_model[addr][n*4 +: 4] = data[n*4 +: 4];
        end
    end
endtask

task automatic fill_words(input vdp_pkg::vram_addr_t start, input int count);
    vdp_pkg::vram_word_t d;
    write_reg(`VDP_REG_VRAM_ADDR, 16'(start));
    for (int i = 0; i < count; i++) begin
        d = vdp_pkg::vram_word_t'($random(seed));
        write_reg(`VDP_REG_VRAM_DATA, d);                   // address steps itself
        model_write(vdp_pkg::vram_addr_t'(start + i), d);
    end
endtask

// returns just after a rising vsync at the ports
task automatic wait_vsync();
    int t;
    t = 0;
    @(negedge clk);
    while (vsync_o) begin
        if (t == SYNC_TIMEOUT) abort_run("timeout waiting for vsync to go low");
        t++;
        @(negedge clk);
    end
    t = 0;
    while (!vsync_o) begin
        if (t == SYNC_TIMEOUT) abort_run("timeout waiting for vsync to go high");
        t++;
        @(negedge clk);
    end
endtask

// one whole frame, vsync to vsync
task automatic check_frame(input vdp_pkg::vram_addr_t base);
    int                   n;
    int                   pos;
    int                   ph;
    int                   pv;
    vdp_pkg::vram_word_t  word;
    vdp_pkg::color_idx_t  idx;
    vdp_pkg::video_sync_t exp_sync;
    n = 0;
    wait_vsync();
    for (int c = 0; c < FRAME_CYCLES; c++) begin
        @(negedge clk);
        // first sample is pixel 1 of the first vsync line
        pos = (`VDP_V_SYNC_START * `VDP_H_TOTAL + 1 + c) % FRAME_CYCLES;
        ph  = pos % `VDP_H_TOTAL;
        pv  = pos / `VDP_H_TOTAL;
        exp_sync.hsync = (ph >= `VDP_H_SYNC_START) && (ph < `VDP_H_SYNC_END);
        exp_sync.vsync = (pv >= `VDP_V_SYNC_START) && (pv < `VDP_V_SYNC_END);
        exp_sync.de    = (ph < `VDP_H_VISIBLE) && (pv < `VDP_V_VISIBLE);
        check_sync("sync", {hsync_o, vsync_o, dv_de_o}, exp_sync);
        if (!dv_de_o) begin
            check_rgb("rgb_blank", {red_o, green_o, blue_o}, 12'h000);
        end else begin
            if (n < FRAME_PIXELS) begin
                word = vram_model[vdp_pkg::vram_addr_t'(base + n / 4)];
                idx  = word[(3 - n % 4) * 4 +: 4];       // leftmost pixel in top nibble
                check_rgb("rgb", {red_o, green_o, blue_o}, pal_model[idx]);
            end
            n++;
        end
    end
    check_count("de_pixels", n, FRAME_PIXELS);
endtask

initial begin
    vdp_pkg::vram_word_t w;
    vdp_pkg::vram_word_t d;
    vdp_pkg::vram_addr_t a;
    int                  p0;
    seed          = 87639;
    clk           = 1'b0;
    reset_i       = 1'b1;
    bus_cs_n_i    = 1'b1;
    bus_rd_nwr_i  = 1'b0;
    bus_reg_num_i = '0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = '0;
    intr_pulses   = 0;
    mask_model    = '0;
    status_model  = '0;
    repeat (10) @(posedge clk);
    #1;
    reset_i = 1'b0;
    read_reg(`VDP_REG_INTR_STATUS, w);                  // well before first vblank
    check_intr("intr_status", vdp_pkg::intr_bits_t'(w), status_model);

    // auto-increment fill, read back one address at a time
    mask_model = 4'hf;
    write_reg(`VDP_REG_WR_MASK, 16'(mask_model));
    fill_words(AREA, NWORDS);
    for (int i = 0; i < NWORDS; i++) begin
        write_reg(`VDP_REG_VRAM_ADDR, 16'(AREA + i));   // reload starts the prefetch
        read_reg(`VDP_REG_VRAM_DATA, w);
        check_word("vram_data", w, vram_model[AREA + i]);
    end

    // random nibble masks
    for (int i = 0; i < 16; i++) begin
        a          = vdp_pkg::vram_addr_t'(AREA + ($random(seed) & 31));
        mask_model = vdp_pkg::nib_mask_t'($random(seed));
        d          = vdp_pkg::vram_word_t'($random(seed));
        write_reg(`VDP_REG_WR_MASK, 16'(mask_model));
        write_reg(`VDP_REG_VRAM_ADDR, 16'(a));
        write_reg(`VDP_REG_VRAM_DATA, d);
        model_write(a, d);
        write_reg(`VDP_REG_VRAM_ADDR, 16'(a));
        read_reg(`VDP_REG_VRAM_DATA, w);
        check_word("vram_data_masked", w, vram_model[a]);
    end

    // palette then one frame
    write_reg(`VDP_REG_PAL_ADDR, 16'h0000);
    for (int i = 0; i < 16; i++) begin
        pal_model[i] = vdp_pkg::rgb_t'($random(seed));
        write_reg(`VDP_REG_PAL_DATA, 16'(pal_model[i]));   // index steps itself
    end
    write_reg(`VDP_REG_DISP_BASE, 16'(AREA));
    check_frame(AREA);

    // second block, frame moved by a random word offset
    mask_model = 4'hf;
    write_reg(`VDP_REG_WR_MASK, 16'(mask_model));
    fill_words(vdp_pkg::vram_addr_t'(AREA + NWORDS), NWORDS);
    a = vdp_pkg::vram_addr_t'(AREA + 1 + ($random(seed) & 31));
    write_reg(`VDP_REG_DISP_BASE, 16'(a));
    check_frame(a);

    // vblank masked in, start with a clean status
    wait_vsync();
    write_reg(`VDP_REG_INTR_CTRL, 16'h0f01);
    status_model = '0;
    read_reg(`VDP_REG_INTR_STATUS, w);
    check_intr("intr_status", vdp_pkg::intr_bits_t'(w), status_model);
    p0 = intr_pulses;
    wait_vsync();                                       // one vblank passed
    check_count("intr_pulses", intr_pulses - p0, 1);
    status_model[0] = 1'b1;
    read_reg(`VDP_REG_INTR_STATUS, w);
    check_intr("intr_status", vdp_pkg::intr_bits_t'(w), status_model);
    p0 = intr_pulses;
    wait_vsync();                                       // bit 0 still pending
    check_count("intr_pulses", intr_pulses - p0, 0);

    // clear bit 0, mask everything out, cpu raises 3:1
    write_reg(`VDP_REG_INTR_CTRL, 16'h0100);
    status_model[0] = 1'b0;
    read_reg(`VDP_REG_INTR_STATUS, w);
    check_intr("intr_status", vdp_pkg::intr_bits_t'(w), status_model);
    p0 = intr_pulses;
    write_reg(`VDP_REG_INTR_STATUS, 16'h000e);
    status_model = status_model | 4'he;
    read_reg(`VDP_REG_INTR_STATUS, w);
    check_intr("intr_status", vdp_pkg::intr_bits_t'(w), status_model);
    wait_vsync();
    status_model[0] = 1'b1;                             // vblank sets it, masked
    read_reg(`VDP_REG_INTR_STATUS, w);
    check_intr("intr_status", vdp_pkg::intr_bits_t'(w), status_model);
    check_count("intr_pulses", intr_pulses - p0, 0);

    $display("TEST PASS");
    $finish;
end

endmodule

// File: verilog.f
+incdir+hw
hw/vdp_pkg.sv
hw/vdp_bus_regs.sv
hw/vdp_video_timing.sv
hw/vdp_pixel_fetch.sv
hw/vdp_vram.sv
hw/vdp_palette.sv
hw/vdp_main.sv
tb/vdp_properties.sv
tb/vdp_tb.sv

// File: Bender.yml
package:
  name: vdp

sources:
  - include_dirs:
      - hw
    files:
      - hw/vdp_pkg.sv
      - hw/vdp_bus_regs.sv
      - hw/vdp_video_timing.sv
      - hw/vdp_pixel_fetch.sv
      - hw/vdp_vram.sv
      - hw/vdp_palette.sv
      - hw/vdp_main.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/vdp_properties.sv
      - tb/vdp_tb.sv
